// ==== tb.f ====
+incdir+rtl
+incdir+verif
rtl/mem_pkg.sv
rtl/l2_req_if.sv
rtl/l1_mem_arbiter.sv
rtl/flush_sequencer.sv
rtl/l2_cache.sv
rtl/mem_subsys_top.sv
verif/tb_mem_subsys.sv

// ==== verif/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

   // lines written so far, keyed by line address
   line_t   mem_model [addr_t];
   logic    model_valid [`L2_LINES];
   l2_tag_t model_tag [`L2_LINES];
   logic    model_last_gnt;
   int      err_cnt;

   function automatic addr_t line_addr(input addr_t a);
      return {a[31:4], 4'h0};
   endfunction

   function automatic line_t mem_read(input addr_t a);
      addr_t la;
      la = line_addr(a);
      if (mem_model.exists(la))
         return mem_model[la];
      return {~la, la ^ 32'h5a5a_a5a5, la * 32'h9e37_79b9, la};   // untouched line pattern
   endfunction

   function automatic void mem_write(input addr_t a, input line_t d);
      mem_model[line_addr(a)] = d;
   endfunction

   // index is bits 7:4, tag bits 31:8
   function automatic bit model_hit(input addr_t a);
      return model_valid[a[7:4]] && (model_tag[a[7:4]] == a[31:8]);
   endfunction

   function automatic void model_fill(input addr_t a);
      model_valid[a[7:4]] = 1'b1;
      model_tag[a[7:4]] = a[31:8];
   endfunction

   function automatic void model_flush();
      foreach (model_valid[i])
         model_valid[i] = 1'b0;
   endfunction

   function automatic void model_reset();
      model_flush();
      model_last_gnt = 1'b0;
      err_cnt = 0;
   endfunction

   // icache wins a tie while the last-grant bit is 0
   function automatic bit tie_goes_to_icache();
      bit win_i;
      win_i = !model_last_gnt;
      model_last_gnt = !model_last_gnt;
      return win_i;
   endfunction

   task automatic report_error(input string msg);
      err_cnt++;
      $display("%s", msg);
   endtask

   task automatic check_line(input string name, input line_t exp, input line_t act);
      if (act !== exp)
      begin
         err_cnt++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (act !== exp)
      begin
         err_cnt++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         err_cnt++;
         $display("Fail %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_op(input string name, input mem_op_t exp, input mem_op_t act);
      if (act !== exp)
      begin
         err_cnt++;
         $display("Fail %s: expected %s, actual %s", name, exp.name(), act.name());
      end
   endtask

`endif

// ==== verif/tb_mem_subsys.sv ====
`default_nettype none

`include "mem_consts.svh"

module tb_mem_subsys;
   timeunit 1ns;
   timeprecision 1ps;
   import mem_pkg::*;

   localparam int N_LOADS = 60;
   localparam int N_STORES = 20;
   localparam int N_TIES = 8;
   localparam int N_FLUSH_LOADS = 25;   // warm-up, pending and reload
   localparam int WORST_MISS = `MEM_LAT_MAX + 8;
   localparam int N_REQS = N_LOADS + 2 * N_STORES + 2 * N_TIES + N_FLUSH_LOADS;
   localparam int TIMEOUT_CYCLES = 2 * (N_REQS * WORST_MISS + `L2_LINES + 64);
   localparam int RSP_WAIT = 4 * WORST_MISS;

   logic    clk;
   logic    reset;
   logic    l1d_req_valid;
   addr_t   l1d_req_addr;
   mem_op_t l1d_req_op;
   line_t   l1d_req_store_data;
   logic    l1d_rsp_valid;
   logic    l1i_req_valid;
   addr_t   l1i_req_addr;
   logic    l1i_rsp_valid;
   line_t   l1_rsp_load_data;
   logic    l1d_flush_req;
   logic    l1i_flush_req;
   logic    l1d_flush_done;
   logic    l1i_flush_done;
   logic    in_flush_mode;
   logic    mem_req_valid;
   addr_t   mem_req_addr;
   mem_op_t mem_req_op;
   line_t   mem_req_store_data;
   logic    mem_rsp_valid;
   line_t   mem_rsp_load_data;

   int          cycle;
   logic [31:0] stim_rng;
   logic [31:0] lat_rng;
   int          tests_passed;
   int          tests_failed;

   // responses as the monitor saw them
   line_t rsp_d_q [$];
   int    rsp_d_cyc [$];
   line_t rsp_i_q [$];
   int    rsp_i_cyc [$];
   bit    order_q [$];   // 1 for icache

   int      mem_cnt;
   addr_t   last_mem_addr;
   mem_op_t last_mem_op;
   line_t   last_mem_data;
   logic    mem_busy;
   int      mem_delay;

   `include "tb_model.svh"

   mem_subsys_top i_mem_subsys_top (
      .clk                (clk),
      .reset              (reset),
      .l1d_req_valid      (l1d_req_valid),
      .l1d_req_addr       (l1d_req_addr),
      .l1d_req_op         (l1d_req_op),
      .l1d_req_store_data (l1d_req_store_data),
      .l1d_rsp_valid      (l1d_rsp_valid),
      .l1i_req_valid      (l1i_req_valid),
      .l1i_req_addr       (l1i_req_addr),
      .l1i_rsp_valid      (l1i_rsp_valid),
      .l1_rsp_load_data   (l1_rsp_load_data),
      .l1d_flush_req      (l1d_flush_req),
      .l1i_flush_req      (l1i_flush_req),
      .l1d_flush_done     (l1d_flush_done),
      .l1i_flush_done     (l1i_flush_done),
      .in_flush_mode      (in_flush_mode),
      .mem_req_valid      (mem_req_valid),
      .mem_req_addr       (mem_req_addr),
      .mem_req_op         (mem_req_op),
      .mem_req_store_data (mem_req_store_data),
      .mem_rsp_valid      (mem_rsp_valid),
      .mem_rsp_load_data  (mem_rsp_load_data)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT_CYCLES)
      begin
         $display("timeout: run stopped after %0d cycles", cycle);
         $display("Regression failed");
         $finish;
      end
   end

   always @(posedge clk)
   begin
      if (l1d_rsp_valid === 1'b1)
      begin
         rsp_d_q.push_back(l1_rsp_load_data);
         rsp_d_cyc.push_back(cycle);
         order_q.push_back(1'b0);
      end
      if (l1i_rsp_valid === 1'b1)
      begin
         rsp_i_q.push_back(l1_rsp_load_data);
         rsp_i_cyc.push_back(cycle);
         order_q.push_back(1'b1);
      end
   end

   // external memory, one request in flight
   always @(posedge clk)
   begin
      mem_rsp_valid <= 1'b0;
      if (mem_req_valid === 1'b1)
      begin
         mem_cnt = mem_cnt + 1;
         last_mem_addr = mem_req_addr;
         last_mem_op = mem_req_op;
         last_mem_data = mem_req_store_data;
         lat_rng = xorshift(lat_rng);
         mem_delay = `MEM_LAT_MIN + int'(lat_rng % (`MEM_LAT_MAX - `MEM_LAT_MIN + 1));
         mem_busy = 1'b1;
      end
      else if (mem_busy)
      begin
         mem_delay = mem_delay - 1;
         if (mem_delay == 1)
         begin
            if (last_mem_op == MEM_STORE)
               mem_write(last_mem_addr, last_mem_data);   // store lands on its ack
            mem_rsp_load_data <= mem_read(last_mem_addr);
            mem_rsp_valid <= 1'b1;
            mem_busy = 1'b0;
         end
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      stim_rng = xorshift(stim_rng);
      return stim_rng;
   endfunction

   // 32 lines over 16 indices, random byte offset
   function automatic addr_t pick_addr();
      logic [31:0] r;
      r = next_rand();
      return 32'h0004_0000 + {r[4:0], 4'h0} + {28'h0, r[11:8]};
   endfunction

   task automatic send_req(input bit to_i, input mem_op_t op, input addr_t a, input line_t d,
                           output int sent_cyc);
      @(posedge clk);
      if (to_i)
      begin
         l1i_req_valid <= 1'b1;
         l1i_req_addr <= a;
      end
      else
      begin
         l1d_req_valid <= 1'b1;
         l1d_req_addr <= a;
         l1d_req_op <= op;
         l1d_req_store_data <= d;
      end
      @(posedge clk);
      sent_cyc = cycle;   // edge where the DUT takes the strobe
      l1d_req_valid <= 1'b0;
      l1i_req_valid <= 1'b0;
   endtask

   task automatic wait_rsp(input bit from_i, input string name, output line_t data,
                           output int cyc, output bit got);
      int waited;
      waited = 0;
      got = 1'b0;
      while (((from_i ? rsp_i_q.size() : rsp_d_q.size()) == 0) && (waited < RSP_WAIT))
      begin
         @(posedge clk);
         waited++;
      end
      if (from_i && (rsp_i_q.size() > 0))
      begin
         data = rsp_i_q.pop_front();
         cyc = rsp_i_cyc.pop_front();
         got = 1'b1;
      end
      else if (!from_i && (rsp_d_q.size() > 0))
      begin
         data = rsp_d_q.pop_front();
         cyc = rsp_d_cyc.pop_front();
         got = 1'b1;
      end
      else
         report_error($sformatf("%s: no response strobe within %0d cycles", name, RSP_WAIT));
   endtask

   task automatic check_mem_req(input string name, input addr_t a, input mem_op_t op,
                                input int mem_before);
      if (mem_cnt - mem_before != 1)
         report_error($sformatf("Fail %s mem requests: expected 1, actual %0d", name,
                                mem_cnt - mem_before));
      else
      begin
         check_addr({name, " mem addr"}, line_addr(a), last_mem_addr);
         check_op({name, " mem op"}, op, last_mem_op);
      end
   endtask

   task automatic do_load(input bit from_i, input addr_t a, input string name);
      bit    hit;
      bit    got;
      int    mem_before;
      int    sent_cyc;
      int    rsp_cyc;
      line_t data;
      hit = model_hit(a);
      mem_before = mem_cnt;
      send_req(from_i, MEM_LOAD, a, '0, sent_cyc);
      wait_rsp(from_i, name, data, rsp_cyc, got);
      if (got)
      begin
         check_line(name, mem_read(a), data);
         if (hit)
         begin
            check_bit({name, " mem_req_valid"}, 1'b0, mem_cnt != mem_before);
            if (rsp_cyc - sent_cyc != 3)
               report_error($sformatf("Fail %s latency: expected 3, actual %0d", name,
                                      rsp_cyc - sent_cyc));
         end
         else
            check_mem_req(name, a, MEM_LOAD, mem_before);
      end
      if (!hit)
         model_fill(a);
   endtask

   task automatic do_store(input addr_t a, input line_t d, input string name);
      bit    got;
      int    mem_before;
      int    sent_cyc;
      int    rsp_cyc;
      line_t data;
      mem_before = mem_cnt;
      send_req(1'b0, MEM_STORE, a, d, sent_cyc);
      wait_rsp(1'b0, name, data, rsp_cyc, got);
      if (got)
      begin
         check_mem_req(name, a, MEM_STORE, mem_before);
         check_line({name, " mem data"}, d, last_mem_data);
      end
   endtask

   task automatic end_test(input string name, input int err_before);
      if (err_cnt == err_before)
      begin
         tests_passed++;
         $display("test %s: ok", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: %0d errors", name, err_cnt - err_before);
      end
   endtask

   task automatic run_rand_loads();
      int          err_before;
      logic [31:0] r;
      err_before = err_cnt;
      for (int i = 0; i < N_LOADS; i++)
      begin
         r = next_rand();
         do_load(r[0], pick_addr(), $sformatf("load %0d", i));
      end
      end_test("random loads", err_before);
   endtask

   task automatic run_write_through();
      int          err_before;
      addr_t       a;
      line_t       d;
      logic [31:0] r;
      err_before = err_cnt;
      for (int i = 0; i < N_STORES; i++)
      begin
         a = pick_addr();
         d = {next_rand(), next_rand(), next_rand(), next_rand()};
         do_store(a, d, $sformatf("store %0d", i));
         r = next_rand();
         do_load(r[0], a, $sformatf("load after store %0d", i));   // a miss stays a miss
      end
      end_test("write-through", err_before);
   endtask

   task automatic run_round_robin();
      int    err_before;
      int    cyc;
      bit    got;
      bit    exp_i_first;
      addr_t a_d;
      addr_t a_i;
      line_t data;
      err_before = err_cnt;
      for (int i = 0; i < N_TIES; i++)
      begin
         a_d = pick_addr();
         a_i = pick_addr();
         order_q.delete();
         exp_i_first = tie_goes_to_icache();
         @(posedge clk);
         l1d_req_valid <= 1'b1;
         l1d_req_addr <= a_d;
         l1d_req_op <= MEM_LOAD;
         l1i_req_valid <= 1'b1;
         l1i_req_addr <= a_i;
         @(posedge clk);
         l1d_req_valid <= 1'b0;
         l1i_req_valid <= 1'b0;
         wait_rsp(1'b1, $sformatf("tie %0d icache", i), data, cyc, got);
         if (got)
            check_line($sformatf("tie %0d icache data", i), mem_read(a_i), data);
         wait_rsp(1'b0, $sformatf("tie %0d dcache", i), data, cyc, got);
         if (got)
            check_line($sformatf("tie %0d dcache data", i), mem_read(a_d), data);
         if (order_q.size() > 0)
            check_bit($sformatf("tie %0d icache first", i), exp_i_first, order_q[0]);
         if (exp_i_first)
         begin
            model_fill(a_i);
            model_fill(a_d);
         end
         else
         begin
            model_fill(a_d);
            model_fill(a_i);
         end
      end
      end_test("round-robin", err_before);
   endtask

   task automatic run_flush();
      int          err_before;
      int          mem_before;
      int          sent_cyc;
      int          cyc;
      int          k;
      bit          got;
      addr_t       pa;
      line_t       data;
      logic [31:0] r;
      logic        saved_valid [`L2_LINES];
      l2_tag_t     saved_tag [`L2_LINES];
      err_before = err_cnt;
      for (int i = 0; i < 8; i++)
         do_load(1'b0, pick_addr(), $sformatf("warm load %0d", i));
      saved_valid = model_valid;
      saved_tag = model_tag;

      @(posedge clk);
      l1d_flush_req <= 1'b1;
      l1i_flush_req <= 1'b1;
      @(posedge clk);
      l1d_flush_req <= 1'b0;
      l1i_flush_req <= 1'b0;
      @(posedge clk);
      check_bit("flush mode rise", 1'b1, in_flush_mode);

      // held back until the flush is over
      mem_before = mem_cnt;
      pa = pick_addr();
      send_req(1'b1, MEM_LOAD, pa, '0, sent_cyc);
      r = next_rand();
      repeat (4 + r[1:0]) @(posedge clk);
      check_bit("flush mode before l1 completions", 1'b1, in_flush_mode);

      @(posedge clk);
      l1d_flush_done <= 1'b1;
      @(posedge clk);
      l1d_flush_done <= 1'b0;
      repeat (3) @(posedge clk);
      check_bit("flush mode after one completion", 1'b1, in_flush_mode);

      @(posedge clk);
      l1i_flush_done <= 1'b1;
      k = 0;
      do
      begin
         @(posedge clk);
         l1i_flush_done <= 1'b0;
         k++;
      end while ((in_flush_mode === 1'b1) && (k < 4 * `L2_LINES));
      if (in_flush_mode !== 1'b0)
         report_error("flush mode never ended after both completions");
      else if (k - 1 != `L2_LINES + 3)
         report_error($sformatf("Fail flush mode length: expected %0d, actual %0d",
                                `L2_LINES + 3, k - 1));
      check_bit("memory request during flush", 1'b0, mem_cnt != mem_before);
      model_flush();

      wait_rsp(1'b1, "load held by flush", data, cyc, got);
      if (got)
      begin
         check_line("load held by flush", mem_read(pa), data);
         check_mem_req("load held by flush", pa, MEM_LOAD, mem_before);
      end
      model_fill(pa);

      for (int i = 0; i < `L2_LINES; i++)
      begin
         if (saved_valid[i])
            do_load(1'b0, {saved_tag[i], l2_idx_t'(i), 4'h0}, $sformatf("reload %0d", i));
      end
      end_test("flush", err_before);
   endtask

   initial
   begin
      reset = 1'b1;
      l1d_req_valid = 1'b0;
      l1d_req_addr = '0;
      l1d_req_op = MEM_LOAD;
      l1d_req_store_data = '0;
      l1i_req_valid = 1'b0;
      l1i_req_addr = '0;
      l1d_flush_req = 1'b0;
      l1i_flush_req = 1'b0;
      l1d_flush_done = 1'b0;
      l1i_flush_done = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp_load_data = '0;
      cycle = 0;
      stim_rng = 32'hc0c0;
      lat_rng = 32'hc0c0;
      mem_cnt = 0;
      mem_busy = 1'b0;
      mem_delay = 0;
      tests_passed = 0;
      tests_failed = 0;
      model_reset();

      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);

      run_rand_loads();
      run_write_through();
      run_round_robin();
      run_flush();

      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if ((tests_failed == 0) && (err_cnt == 0))
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== rtl/mem_subsys_top.sv ====
`default_nettype none

module mem_subsys_top (
   input  logic              clk,
   input  logic              reset,
   input  logic              l1d_req_valid,
   input  mem_pkg::addr_t    l1d_req_addr,
   input  mem_pkg::mem_op_t  l1d_req_op,
   input  mem_pkg::line_t    l1d_req_store_data,
   output logic              l1d_rsp_valid,
   input  logic              l1i_req_valid,
   input  mem_pkg::addr_t    l1i_req_addr,
   output logic              l1i_rsp_valid,
   output mem_pkg::line_t    l1_rsp_load_data,
   input  logic              l1d_flush_req,
   input  logic              l1i_flush_req,
   input  logic              l1d_flush_done,
   input  logic              l1i_flush_done,
   output logic              in_flush_mode,
   output logic              mem_req_valid,
   output mem_pkg::addr_t    mem_req_addr,
   output mem_pkg::mem_op_t  mem_req_op,
   output mem_pkg::line_t    mem_req_store_data,
   input  logic              mem_rsp_valid,
   input  mem_pkg::line_t    mem_rsp_load_data
);

   logic l2_flush_req;
   logic l2_flush_done;

   l2_req_if l2_bus ();

   l1_mem_arbiter i_arbiter (
      .clk                (clk),
      .reset              (reset),
      .l1d_req_valid      (l1d_req_valid),
      .l1d_req_addr       (l1d_req_addr),
      .l1d_req_op         (l1d_req_op),
      .l1d_req_store_data (l1d_req_store_data),
      .l1i_req_valid      (l1i_req_valid),
      .l1i_req_addr       (l1i_req_addr),
      .in_flush_mode      (in_flush_mode),
      .l1d_rsp_valid      (l1d_rsp_valid),
      .l1i_rsp_valid      (l1i_rsp_valid),
      .l2                 (l2_bus.arbiter)
   );

   flush_sequencer i_flush_seq (
      .clk            (clk),
      .reset          (reset),
      .l1d_flush_req  (l1d_flush_req),
      .l1i_flush_req  (l1i_flush_req),
      .l1d_flush_done (l1d_flush_done),
      .l1i_flush_done (l1i_flush_done),
      .l2_flush_done  (l2_flush_done),
      .l2_flush_req   (l2_flush_req),
      .in_flush_mode  (in_flush_mode)
   );

   l2_cache i_l2_cache (
      .clk                (clk),
      .reset              (reset),
      .l1                 (l2_bus.cache),
      .l2_flush_req       (l2_flush_req),
      .l2_flush_done      (l2_flush_done),
      .mem_req_valid      (mem_req_valid),
      .mem_req_addr       (mem_req_addr),
      .mem_req_op         (mem_req_op),
      .mem_req_store_data (mem_req_store_data),
      .mem_rsp_valid      (mem_rsp_valid),
      .mem_rsp_load_data  (mem_rsp_load_data)
   );

   // both l1s share the response data, qualified by their own strobe
   assign l1_rsp_load_data = l2_bus.rsp_load_data;

endmodule

`default_nettype wire

// ==== rtl/l2_cache.sv ====
`default_nettype none

`include "mem_consts.svh"

module l2_cache (
   input  logic              clk,
   input  logic              reset,
   l2_req_if.cache           l1,
   input  logic              l2_flush_req,
   output logic              l2_flush_done,
   output logic              mem_req_valid,
   output mem_pkg::addr_t    mem_req_addr,
   output mem_pkg::mem_op_t  mem_req_op,
   output mem_pkg::line_t    mem_req_store_data,
   input  logic              mem_rsp_valid,
   input  mem_pkg::line_t    mem_rsp_load_data
);
   import mem_pkg::*;

   l2_tag_t                r_tag_arr [`L2_LINES];
   line_t                  r_data_arr [`L2_LINES];
   logic [`L2_LINES-1:0]   r_valid;

   // registered request
   logic    r_lookup;
   addr_t   r_addr;
   mem_op_t r_op;
   line_t   r_store_data;

   logic    r_mem_wait;
   logic    r_mem_req_valid;
   logic    r_rsp_valid;
   line_t   r_rsp_data;

   logic    r_flushing;
   l2_idx_t r_flush_idx;
   logic    r_flush_done;

   l2_idx_t w_idx;
   l2_tag_t w_tag;
   logic    w_hit;
   logic    w_fill;

   assign w_idx = r_addr[`LG_LINE_BYTES +: `LG_L2_LINES];
   assign w_tag = r_addr[`MEM_ADDR_W-1:`LG_LINE_BYTES+`LG_L2_LINES];
   assign w_hit = r_valid[w_idx] && (r_tag_arr[w_idx] == w_tag);
   assign w_fill = r_mem_wait && mem_rsp_valid && (r_op == MEM_LOAD);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_lookup <= 1'b0;
         r_mem_wait <= 1'b0;
         r_mem_req_valid <= 1'b0;
         r_rsp_valid <= 1'b0;
         r_valid <= '0;
         r_flushing <= 1'b0;
         r_flush_idx <= '0;
         r_flush_done <= 1'b0;
      end
      else
      begin
         r_lookup <= l1.req_valid;
         r_mem_req_valid <= 1'b0;
         r_rsp_valid <= 1'b0;
         r_flush_done <= 1'b0;

         if (r_lookup)
         begin
            if (w_hit && (r_op == MEM_LOAD))
               r_rsp_valid <= 1'b1;
            else
            begin
               // load miss or any store goes out to memory
               r_mem_req_valid <= 1'b1;
               r_mem_wait <= 1'b1;
            end
         end

         if (r_mem_wait && mem_rsp_valid)
         begin
            r_mem_wait <= 1'b0;
            r_rsp_valid <= 1'b1;
            if (w_fill)
               r_valid[w_idx] <= 1'b1;
         end

         if (l2_flush_req)
         begin
            r_flushing <= 1'b1;
            r_flush_idx <= '0;
         end
         else if (r_flushing)
         begin
            r_valid[r_flush_idx] <= 1'b0;   // invalidate only, nothing dirty
            r_flush_idx <= r_flush_idx + 1'b1;
            if (r_flush_idx == l2_idx_t'(`L2_LINES-1))
            begin
               r_flushing <= 1'b0;
               r_flush_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (l1.req_valid)
      begin
         r_addr <= l1.req_addr;
         r_op <= l1.req_op;
         r_store_data <= l1.req_store_data;
      end

      if (r_lookup && w_hit)
      begin
         r_rsp_data <= r_data_arr[w_idx];
         if (r_op == MEM_STORE)
            r_data_arr[w_idx] <= r_store_data;   // store hit updates in place
      end

      if (w_fill)
      begin
         r_tag_arr[w_idx] <= w_tag;
         r_data_arr[w_idx] <= mem_rsp_load_data;
         r_rsp_data <= mem_rsp_load_data;
      end
   end

   assign l1.rsp_valid = r_rsp_valid;
   assign l1.rsp_load_data = r_rsp_data;

   assign mem_req_valid = r_mem_req_valid;
   assign mem_req_addr = {w_tag, w_idx, {`LG_LINE_BYTES{1'b0}}};   // line aligned
   assign mem_req_op = r_op;
   assign mem_req_store_data = r_store_data;

   assign l2_flush_done = r_flush_done;

endmodule

`default_nettype wire

// ==== rtl/flush_sequencer.sv ====
`default_nettype none

module flush_sequencer (
   input  logic clk,
   input  logic reset,
   input  logic l1d_flush_req,
   input  logic l1i_flush_req,
   input  logic l1d_flush_done,
   input  logic l1i_flush_done,
   input  logic l2_flush_done,
   output logic l2_flush_req,
   output logic in_flush_mode
);
   import mem_pkg::*;

   flush_state_t r_state, n_state;
   logic         r_l2_flush_req, n_l2_flush_req;

   always_comb
   begin
      n_state = r_state;
      n_l2_flush_req = 1'b0;

      case (r_state)
         FLUSH_IDLE:
         begin
            // an l1 not asked to flush counts as already done
            if (l1d_flush_req && l1i_flush_req)
               n_state = WAIT_BOTH;
            else if (l1d_flush_req)
               n_state = GOT_L1I;
            else if (l1i_flush_req)
               n_state = GOT_L1D;
         end
         WAIT_BOTH:
         begin
            if (l1d_flush_done && l1i_flush_done)
            begin
               n_state = FLUSH_L2;
               n_l2_flush_req = 1'b1;
            end
            else if (l1d_flush_done)
               n_state = GOT_L1D;
            else if (l1i_flush_done)
               n_state = GOT_L1I;
         end
         GOT_L1D:
         begin
            if (l1i_flush_done)
            begin
               if (l1d_flush_req)
                  n_state = GOT_L1I;   // late l1d request still owed
               else
               begin
                  n_state = FLUSH_L2;
                  n_l2_flush_req = 1'b1;
               end
            end
            else if (l1d_flush_req)
               n_state = WAIT_BOTH;
         end
         GOT_L1I:
         begin
            if (l1d_flush_done)
            begin
               if (l1i_flush_req)
                  n_state = GOT_L1D;
               else
               begin
                  n_state = FLUSH_L2;
                  n_l2_flush_req = 1'b1;
               end
            end
            else if (l1i_flush_req)
               n_state = WAIT_BOTH;
         end
         FLUSH_L2:
         begin
            if (l2_flush_done)
               n_state = FLUSH_IDLE;
         end
         default:
            n_state = FLUSH_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= FLUSH_IDLE;
         r_l2_flush_req <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_l2_flush_req <= n_l2_flush_req;
      end
   end

   assign l2_flush_req = r_l2_flush_req;
   assign in_flush_mode = (r_state != FLUSH_IDLE);

endmodule

`default_nettype wire

// ==== rtl/l1_mem_arbiter.sv ====
`default_nettype none

module l1_mem_arbiter (
   input  logic              clk,
   input  logic              reset,
   input  logic              l1d_req_valid,
   input  mem_pkg::addr_t    l1d_req_addr,
   input  mem_pkg::mem_op_t  l1d_req_op,
   input  mem_pkg::line_t    l1d_req_store_data,
   input  logic              l1i_req_valid,
   input  mem_pkg::addr_t    l1i_req_addr,
   input  logic              in_flush_mode,
   output logic              l1d_rsp_valid,
   output logic              l1i_rsp_valid,
   l2_req_if.arbiter         l2
);
   import mem_pkg::*;

   arb_state_t r_state, n_state;
   logic       r_l1d_pend, n_l1d_pend;
   logic       r_l1i_pend, n_l1i_pend;
   logic       r_last_gnt, n_last_gnt;
   logic       r_req_valid, n_req_valid;

   addr_t      r_l1d_addr;
   mem_op_t    r_l1d_op;
   line_t      r_l1d_data;
   addr_t      r_l1i_addr;

   always_comb
   begin
      n_state = r_state;
      n_last_gnt = r_last_gnt;
      n_l1d_pend = r_l1d_pend | l1d_req_valid;
      n_l1i_pend = r_l1i_pend | l1i_req_valid;
      n_req_valid = 1'b0;
      l1d_rsp_valid = 1'b0;
      l1i_rsp_valid = 1'b0;

      case (r_state)
         ARB_IDLE:
         begin
            if (!in_flush_mode)
            begin
               if (n_l1d_pend && n_l1i_pend)
               begin
                  // contested: last grant bit decides, then flips
                  n_state = r_last_gnt ? GNT_L1D : GNT_L1I;
                  n_last_gnt = !r_last_gnt;
               end
               else if (n_l1d_pend)
               begin
                  n_state = GNT_L1D;
               end
               else if (n_l1i_pend)
               begin
                  n_state = GNT_L1I;
               end

               if (n_state == GNT_L1D)
               begin
                  n_l1d_pend = 1'b0;
                  n_req_valid = 1'b1;
               end
               else if (n_state == GNT_L1I)
               begin
                  n_l1i_pend = 1'b0;
                  n_req_valid = 1'b1;
               end
            end
         end
         GNT_L1D:
         begin
            if (l2.rsp_valid)
            begin
               l1d_rsp_valid = 1'b1;
               n_state = ARB_IDLE;
            end
         end
         GNT_L1I:
         begin
            if (l2.rsp_valid)
            begin
               l1i_rsp_valid = 1'b1;
               n_state = ARB_IDLE;
            end
         end
         default:
         begin
            n_state = ARB_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= ARB_IDLE;
         r_l1d_pend <= 1'b0;
         r_l1i_pend <= 1'b0;
         r_last_gnt <= 1'b0;   // icache wins the first tie
         r_req_valid <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_l1d_pend <= n_l1d_pend;
         r_l1i_pend <= n_l1i_pend;
         r_last_gnt <= n_last_gnt;
         r_req_valid <= n_req_valid;
      end
   end

   // request payload captured with its strobe
   always_ff @(posedge clk)
   begin
      if (l1d_req_valid)
      begin
         r_l1d_addr <= l1d_req_addr;
         r_l1d_op <= l1d_req_op;
         r_l1d_data <= l1d_req_store_data;
      end
      if (l1i_req_valid)
      begin
         r_l1i_addr <= l1i_req_addr;
      end
   end

   assign l2.req_valid = r_req_valid;
   assign l2.req_addr = (r_state == GNT_L1I) ? r_l1i_addr : r_l1d_addr;
   assign l2.req_op = (r_state == GNT_L1I) ? MEM_LOAD : r_l1d_op;   // icache only loads
   assign l2.req_store_data = r_l1d_data;

endmodule

`default_nettype wire

// ==== rtl/l2_req_if.sv ====
`default_nettype none

interface l2_req_if;
   import mem_pkg::*;

   logic    req_valid;       // one-cycle strobe
   addr_t   req_addr;
   mem_op_t req_op;
   line_t   req_store_data;

   logic    rsp_valid;       // one-cycle strobe
   line_t   rsp_load_data;   // only meaningful on loads

   modport arbiter (
      output req_valid, req_addr, req_op, req_store_data,
      input  rsp_valid, rsp_load_data
   );

   modport cache (
      input  req_valid, req_addr, req_op, req_store_data,
      output rsp_valid, rsp_load_data
   );

endinterface

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
`default_nettype none

`include "mem_consts.svh"

package mem_pkg;

   typedef logic [`MEM_ADDR_W-1:0] addr_t;   // byte address
   typedef logic [`MEM_LINE_W-1:0] line_t;

   // address split: tag | index | byte offset
   typedef logic [`LG_L2_LINES-1:0] l2_idx_t;
   typedef logic [`MEM_ADDR_W-`LG_L2_LINES-`LG_LINE_BYTES-1:0] l2_tag_t;

   typedef enum logic {
      MEM_LOAD  = 1'b0,
      MEM_STORE = 1'b1
   } mem_op_t;

   typedef enum logic [1:0] {
      ARB_IDLE = 2'd0,
      GNT_L1D  = 2'd1,
      GNT_L1I  = 2'd2
   } arb_state_t;

   typedef enum logic [2:0] {
      FLUSH_IDLE = 3'd0,
      WAIT_BOTH  = 3'd1,
      GOT_L1D    = 3'd2,   // l1d side complete
      GOT_L1I    = 3'd3,   // l1i side complete
      FLUSH_L2   = 3'd4
   } flush_state_t;

endpackage

`default_nettype wire

// ==== rtl/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

`define MEM_ADDR_W     32
`define MEM_LINE_W     128
`define LG_LINE_BYTES  4   // byte offset bits within a line

`define L2_LINES       16
`define LG_L2_LINES    4

// external memory response window, in cycles after mem_req_valid
`define MEM_LAT_MIN    3
`define MEM_LAT_MAX    8

`endif
